//--- filelist.f
source/arcade_input_pkg.sv
source/ps2_key_decoder.sv
source/player_merge.sv
source/cabinet_ports.sv
source/dip_switch_bank.sv
source/arcade_input_top.sv
sim/tb_arcade_input.sv

//--- Makefile
# Verilator build for the arcade input front end

VERILATOR  ?= verilator
TOP        := tb_arcade_input
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := NO ERRORS
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_arcade_input.sv
//////////////////////////////////////////////////
// Testbench for the arcade input front end
// Reference model plus assertions on every port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_arcade_input
    import arcade_input_pkg::*;
;

    localparam int NUM_PLAYERS     = 2;
    localparam int EXPECTED_CYCLES = 600;
    // Three times the expected length plus margin
    localparam int MAX_CYCLES      = EXPECTED_CYCLES * 3 + 200;

    // Scan codes from the key map, then codes the design must ignore
    localparam logic [7:0] KEY_CODES [13] = '{
        8'h16, 8'h1E, 8'h2E, 8'h36, 8'h4D, 8'h75, 8'h72,
        8'h6B, 8'h74, 8'h14, 8'h11, 8'h29, 8'h12
    };
    localparam logic [7:0] UNKNOWN_CODES [3] = '{8'h00, 8'h1C, 8'hF0};

    logic                        CLK_32M;
    logic                        rst_n;
    ps2_key_t                    ps2_key;
    pad_t                        pads [NUM_PLAYERS];
    logic                        osd_pause_en;
    logic                        osd_status;
    dip_write_t                  dip_write;
    logic [1:0]                  coin_n;
    logic [1:0]                  start_n;
    logic [NUM_PLAYERS-1:0][3:0] joystick_n;
    logic [NUM_PLAYERS-1:0][3:0] buttons_n;
    logic                        pause;
    logic [15:0]                 dip_sw;

    int unsigned cycle_count = 0;
    int unsigned port_errors = 0;
    int unsigned pause_errors = 0;
    int unsigned dip_errors = 0;

    arcade_input_top #(
        .NUM_PLAYERS (NUM_PLAYERS)
    ) arcade_input_top_inst (
        .CLK_32M      (CLK_32M),
        .rst_n        (rst_n),
        .ps2_key      (ps2_key),
        .pads         (pads),
        .osd_pause_en (osd_pause_en),
        .osd_status   (osd_status),
        .dip_write    (dip_write),
        .coin_n       (coin_n),
        .start_n      (start_n),
        .joystick_n   (joystick_n),
        .buttons_n    (buttons_n),
        .pause        (pause),
        .dip_sw       (dip_sw)
    );

    initial CLK_32M = 1'b0;
    always #20 CLK_32M = ~CLK_32M;

    always @(posedge CLK_32M) cycle_count <= cycle_count + 1;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    key_state_t                  exp_keys;
    logic                        exp_toggle;
    logic [NUM_PLAYERS-1:0][3:0] ref_joy, ref_btn;
    logic                        ref_start1, ref_start2, ref_coin1, ref_pause;
    logic                        ref_tgl_next;
    logic [1:0]                  exp_coin_n, exp_start_n;
    logic [NUM_PLAYERS-1:0][3:0] exp_joy_n, exp_btn_n;
    logic                        exp_pause_q, exp_tgl, exp_pause;
    logic [7:0][7:0]             exp_dip;
    logic [15:0]                 exp_dip_sw;

    // Held keys follow make and break events
    always @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            exp_toggle <= 1'b0;
            exp_keys   <= '0;
        end else begin
            exp_toggle <= ps2_key.toggle;
            if (ps2_key.toggle != exp_toggle) begin
                case (ps2_key.code)
                    8'h16: exp_keys.start1 <= ps2_key.pressed;
                    8'h1E: exp_keys.start2 <= ps2_key.pressed;
                    8'h2E: exp_keys.coin1  <= ps2_key.pressed;
                    8'h36: exp_keys.coin2  <= ps2_key.pressed;
                    8'h4D: exp_keys.pause  <= ps2_key.pressed;
                    8'h75: exp_keys.up     <= ps2_key.pressed;
                    8'h72: exp_keys.down   <= ps2_key.pressed;
                    8'h6B: exp_keys.left   <= ps2_key.pressed;
                    8'h74: exp_keys.right  <= ps2_key.pressed;
                    8'h14: exp_keys.a      <= ps2_key.pressed;
                    8'h11: exp_keys.b      <= ps2_key.pressed;
                    8'h29: exp_keys.x      <= ps2_key.pressed;
                    8'h12: exp_keys.y      <= ps2_key.pressed;
                    default: ;
                endcase
            end
        end
    end

    // Keyboard OR pad, system requests from any player
    always_comb begin
        ref_start1 = exp_keys.start1;
        ref_start2 = exp_keys.start2;
        ref_coin1  = exp_keys.coin1;
        ref_pause  = exp_keys.pause;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            ref_joy[p] = {exp_keys.up | pads[p][3], exp_keys.down | pads[p][2],
                          exp_keys.left | pads[p][1], exp_keys.right | pads[p][0]};
            ref_btn[p] = {exp_keys.a | pads[p][4], exp_keys.b | pads[p][5],
                          exp_keys.x | pads[p][6], exp_keys.y | pads[p][7]};
            ref_start1 = ref_start1 | pads[p][8];
            ref_coin1  = ref_coin1 | pads[p][9];
            ref_start2 = ref_start2 | pads[p][10];
            ref_pause  = ref_pause | pads[p][11];
        end
    end

    assign ref_tgl_next = exp_tgl ^ (ref_pause & ~exp_pause_q);

    always @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            exp_coin_n  <= '1;
            exp_start_n <= '1;
            exp_joy_n   <= '1;
            exp_btn_n   <= '1;
            exp_pause_q <= 1'b0;
            exp_tgl     <= 1'b0;
            exp_pause   <= 1'b0;
        end else begin
            exp_coin_n  <= ~{exp_keys.coin2, ref_coin1};
            exp_start_n <= ~{ref_start2, ref_start1};
            exp_joy_n   <= ~ref_joy;
            exp_btn_n   <= ~ref_btn;
            exp_pause_q <= ref_pause;
            exp_tgl     <= ref_tgl_next;
            exp_pause   <= ref_tgl_next | (osd_pause_en & osd_status);
        end
    end

    // DIP bytes, written only through index 254 below address 8
    always @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            exp_dip <= '0;
        end else if (dip_write.wr && dip_write.index == 8'd254 && dip_write.addr < 17'd8) begin
            exp_dip[dip_write.addr[2:0]] <= dip_write.data;
        end
    end

    assign exp_dip_sw = ~{exp_dip[1], exp_dip[0]};

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_coin: assert property (@(posedge CLK_32M) disable iff (!rst_n) coin_n == exp_coin_n)
        else begin
            port_errors++;
            $display("** Error at %0t: coin_n is %b, expected %b",
                     $time, $sampled(coin_n), $sampled(exp_coin_n));
        end

    a_start: assert property (@(posedge CLK_32M) disable iff (!rst_n) start_n == exp_start_n)
        else begin
            port_errors++;
            $display("** Error at %0t: start_n is %b, expected %b",
                     $time, $sampled(start_n), $sampled(exp_start_n));
        end

    a_joystick: assert property (@(posedge CLK_32M) disable iff (!rst_n)
                                 joystick_n == exp_joy_n)
        else begin
            port_errors++;
            $display("** Error at %0t: joystick_n is %h, expected %h",
                     $time, $sampled(joystick_n), $sampled(exp_joy_n));
        end

    a_buttons: assert property (@(posedge CLK_32M) disable iff (!rst_n) buttons_n == exp_btn_n)
        else begin
            port_errors++;
            $display("** Error at %0t: buttons_n is %h, expected %h",
                     $time, $sampled(buttons_n), $sampled(exp_btn_n));
        end

    a_pause: assert property (@(posedge CLK_32M) disable iff (!rst_n) pause == exp_pause)
        else begin
            pause_errors++;
            $display("** Error at %0t: pause is %b, expected %b",
                     $time, $sampled(pause), $sampled(exp_pause));
        end

    a_dip: assert property (@(posedge CLK_32M) disable iff (!rst_n) dip_sw == exp_dip_sw)
        else begin
            dip_errors++;
            $display("** Error at %0t: dip_sw is %h, expected %h",
                     $time, $sampled(dip_sw), $sampled(exp_dip_sw));
        end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic idle(input int n);
        repeat (n) @(negedge CLK_32M);
    endtask

    // One make or break event, then wait out the two-stage latency
    task automatic send_key(input logic [7:0] code, input logic pressed);
        @(negedge CLK_32M);
        ps2_key.toggle   = ~ps2_key.toggle;
        ps2_key.pressed  = pressed;
        ps2_key.extended = 1'($urandom);
        ps2_key.code     = code;
        idle(3);
    endtask

    task automatic set_pad(input int p, input pad_t value);
        @(negedge CLK_32M);
        pads[p] = value;
        idle(2);
    endtask

    task automatic write_dip(input logic [7:0] index, input logic [16:0] addr,
                             input logic [7:0] data, input logic wr);
        @(negedge CLK_32M);
        dip_write.wr    = wr;
        dip_write.index = index;
        dip_write.addr  = addr;
        dip_write.data  = data;
        @(negedge CLK_32M);
        dip_write.wr = 1'b0;
        idle(1);
    endtask

    initial begin : watchdog
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(95));
        rst_n        = 1'b0;
        ps2_key      = '0;
        pads[0]      = '0;
        pads[1]      = '0;
        osd_pause_en = 1'b0;
        osd_status   = 1'b0;
        dip_write    = '0;
        idle(2);
        rst_n = 1'b1;
        idle(3);

        // Every known key pressed and released, unknown codes ignored
        for (int i = 0; i < 13; i++) begin
            send_key(KEY_CODES[i], 1'b1);
            send_key(KEY_CODES[i], 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            send_key(UNKNOWN_CODES[i], 1'b1);
            send_key(UNKNOWN_CODES[i], 1'b0);
        end

        // Random directions and buttons per player
        for (int i = 0; i < 20; i++) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                set_pad(p, 16'($urandom) & 16'h00FF);
            end
        end
        set_pad(0, '0);
        set_pad(1, '0);

        // Start 1, coin 1, start 2 and unused bits from each pad
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            set_pad(p, 16'h0100);
            set_pad(p, 16'h0200);
            set_pad(p, 16'h0400);
            set_pad(p, 16'hF000);
            set_pad(p, '0);
        end
        send_key(8'h36, 1'b1);
        set_pad(1, 16'h0300);
        send_key(8'h36, 1'b0);
        set_pad(1, '0);

        // Pause toggles from the keyboard and both pads
        repeat (2) begin
            send_key(8'h4D, 1'b1);
            send_key(8'h4D, 1'b0);
        end
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            set_pad(p, 16'h0800);
            set_pad(p, '0);
        end
        @(negedge CLK_32M);
        osd_pause_en = 1'b1;
        osd_status   = 1'b1;
        idle(4);
        osd_status = 1'b0;
        idle(3);
        // OSD open without pause enabled
        osd_pause_en = 1'b0;
        osd_status   = 1'b1;
        idle(3);
        osd_status = 1'b0;
        idle(2);

        // DIP bytes, then writes the bank must ignore
        write_dip(8'd254, 17'd0, 8'hA5, 1'b1);
        write_dip(8'd254, 17'd1, 8'h3C, 1'b1);
        write_dip(8'd253, 17'd0, 8'hFF, 1'b1);
        write_dip(8'd254, 17'd8, 8'hFF, 1'b1);
        write_dip(8'd254, 17'h10001, 8'hFF, 1'b1);
        write_dip(8'd254, 17'd1, 8'h00, 1'b0);
        for (int a = 0; a < 8; a++) begin
            write_dip(8'd254, 17'(a), 8'($urandom), 1'b1);
        end
        idle(3);

        $display("Error counts: ports %0d, pause %0d, dip switches %0d",
                 port_errors, pause_errors, dip_errors);
        if (port_errors + pause_errors + dip_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- source/arcade_input_top.sv
//////////////////////////////////////////////////
// Controls and DIP front end of the arcade core
// Keyboard and pads in, cabinet ports out
//////////////////////////////////////////////////

`timescale 1ns/1ps

module arcade_input_top
    import arcade_input_pkg::*;
#(
    parameter int NUM_PLAYERS = 2
) (
    input  logic                        CLK_32M,
    input  logic                        rst_n,
    input  ps2_key_t                    ps2_key,
    input  pad_t                        pads [NUM_PLAYERS],
    input  logic                        osd_pause_en,
    input  logic                        osd_status,
    input  dip_write_t                  dip_write,
    output logic [1:0]                  coin_n,
    output logic [1:0]                  start_n,
    output logic [NUM_PLAYERS-1:0][3:0] joystick_n,
    output logic [NUM_PLAYERS-1:0][3:0] buttons_n,
    output logic                        pause,
    output logic [15:0]                 dip_sw
);

    key_state_t   keys;
    player_ctrl_t ctrl [NUM_PLAYERS];

    ps2_key_decoder ps2_key_decoder_inst (
        .CLK_32M (CLK_32M),
        .rst_n   (rst_n),
        .ps2_key (ps2_key),
        .keys    (keys)
    );

    // One merge stage per player
    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        player_merge player_merge_inst (
            .keys (keys),
            .pad  (pads[p]),
            .ctrl (ctrl[p])
        );
    end

    cabinet_ports #(
        .NUM_PLAYERS (NUM_PLAYERS)
    ) cabinet_ports_inst (
        .CLK_32M      (CLK_32M),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .keys         (keys),
        .osd_pause_en (osd_pause_en),
        .osd_status   (osd_status),
        .coin_n       (coin_n),
        .start_n      (start_n),
        .joystick_n   (joystick_n),
        .buttons_n    (buttons_n),
        .pause        (pause)
    );

    dip_switch_bank dip_switch_bank_inst (
        .CLK_32M   (CLK_32M),
        .rst_n     (rst_n),
        .dip_write (dip_write),
        .dip_sw    (dip_sw)
    );

endmodule

//--- source/dip_switch_bank.sv
//////////////////////////////////////////////////
// DIP switch bytes written by the download channel
// Bytes 1 and 0 are presented inverted to the core
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dip_switch_bank
    import arcade_input_pkg::*;
(
    input  logic        CLK_32M,
    input  logic        rst_n,
    input  dip_write_t  dip_write,
    output logic [15:0] dip_sw
);

    localparam int ADDR_W = $clog2(DIP_BYTES);

    logic [DIP_BYTES-1:0][7:0] dip_mem;
    logic                      dip_accept;

    // Only the DIP index and addresses inside the bank are taken
    assign dip_accept = dip_write.wr
                     && (dip_write.index == DIP_INDEX)
                     && (dip_write.addr < 17'(DIP_BYTES));

    always_ff @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            dip_mem <= '0;
        end else if (dip_accept) begin
            dip_mem[dip_write.addr[ADDR_W-1:0]] <= dip_write.data;
        end
    end

    // Switches are active low on the core side
    assign dip_sw = ~{dip_mem[1], dip_mem[0]};

    // Stored bytes hold between accepted writes
    a_dip_hold: assert property (
        @(posedge CLK_32M) disable iff (!rst_n)
        !dip_accept |=> $stable(dip_mem)
    ) else $error("DIP bank changed without an accepted write");

endmodule

//--- source/cabinet_ports.sv
//////////////////////////////////////////////////
// Registered active-low cabinet ports and pause
// Fed by all player merge stages plus the keyboard
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cabinet_ports
    import arcade_input_pkg::*;
#(
    parameter int NUM_PLAYERS = 2
) (
    input  logic                        CLK_32M,
    input  logic                        rst_n,
    input  player_ctrl_t                ctrl [NUM_PLAYERS],
    input  key_state_t                  keys,
    input  logic                        osd_pause_en,
    input  logic                        osd_status,
    output logic [1:0]                  coin_n,
    output logic [1:0]                  start_n,
    output logic [NUM_PLAYERS-1:0][3:0] joystick_n,
    output logic [NUM_PLAYERS-1:0][3:0] buttons_n,
    output logic                        pause
);

    logic [NUM_PLAYERS-1:0] req_start1;
    logic [NUM_PLAYERS-1:0] req_coin1;
    logic [NUM_PLAYERS-1:0] req_start2;
    logic [NUM_PLAYERS-1:0] req_pause;
    logic m_start1, m_start2, m_coin1, m_coin2, m_pause;
    logic pause_btn_q;
    logic pause_rise;
    logic pause_tgl;
    logic pause_tgl_next;

    // Gather the system requests of every player
    always_comb begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            req_start1[p] = ctrl[p].start1;
            req_coin1[p]  = ctrl[p].coin1;
            req_start2[p] = ctrl[p].start2;
            req_pause[p]  = ctrl[p].pause;
        end
    end

    assign m_start1 = keys.start1 | (|req_start1);
    assign m_start2 = keys.start2 | (|req_start2);
    assign m_coin1  = keys.coin1 | (|req_coin1);
    assign m_coin2  = keys.coin2;                    // keyboard only
    assign m_pause  = keys.pause | (|req_pause);

    assign pause_rise     = m_pause & ~pause_btn_q;
    assign pause_tgl_next = pause_tgl ^ pause_rise;

    always_ff @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            coin_n      <= '1;
            start_n     <= '1;
            joystick_n  <= '1;
            buttons_n   <= '1;
            pause_btn_q <= 1'b0;
            pause_tgl   <= 1'b0;
            pause       <= 1'b0;
        end else begin
            coin_n      <= ~{m_coin2, m_coin1};
            start_n     <= ~{m_start2, m_start1};
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                joystick_n[p] <= ~ctrl[p].joystick;
                buttons_n[p]  <= ~ctrl[p].buttons;
            end
            pause_btn_q <= m_pause;
            pause_tgl   <= pause_tgl_next;
            // OSD open with pause enabled holds the core paused
            pause       <= pause_tgl_next | (osd_pause_en & osd_status);
        end
    end

    // Pause toggle only flips on a new press
    a_pause_toggle: assert property (
        @(posedge CLK_32M) disable iff (!rst_n)
        !pause_rise |=> $stable(pause_tgl)
    ) else $error("pause toggled without a pause press");

endmodule

//--- source/player_merge.sv
//////////////////////////////////////////////////
// One player's gamepad merged with the keyboard
//////////////////////////////////////////////////

`timescale 1ns/1ps

module player_merge
    import arcade_input_pkg::*;
(
    input  key_state_t   keys,
    input  pad_t         pad,
    output player_ctrl_t ctrl
);

    // Directions in up, down, left, right order
    assign ctrl.joystick = {
        keys.up    | pad[PAD_UP],
        keys.down  | pad[PAD_DOWN],
        keys.left  | pad[PAD_LEFT],
        keys.right | pad[PAD_RIGHT]
    };

    // Buttons in a, b, x, y order
    assign ctrl.buttons = {
        keys.a | pad[PAD_A],
        keys.b | pad[PAD_B],
        keys.x | pad[PAD_X],
        keys.y | pad[PAD_Y]
    };

    // System requests come from the pad only,
    // the keyboard side is added once in the port register
    assign ctrl.start1 = pad[PAD_START1];
    assign ctrl.coin1  = pad[PAD_COIN1];
    assign ctrl.start2 = pad[PAD_START2];
    assign ctrl.pause  = pad[PAD_PAUSE];

endmodule

//--- source/ps2_key_decoder.sv
//////////////////////////////////////////////////
// Turns toggle-marked keyboard events into held
// button levels for the player merge stage
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ps2_key_decoder
    import arcade_input_pkg::*;
(
    input  logic       CLK_32M,
    input  logic       rst_n,
    input  ps2_key_t   ps2_key,
    output key_state_t keys
);

    logic toggle_q;
    logic key_event;

    // A new event is marked by the toggle bit changing
    assign key_event = ps2_key.toggle != toggle_q;

    always_ff @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            toggle_q <= 1'b0;
            keys     <= '0;
        end else begin
            toggle_q <= ps2_key.toggle;
            if (key_event) begin
                case (ps2_key.code)
                    // System keys
                    KEY_START1: keys.start1 <= ps2_key.pressed;
                    KEY_START2: keys.start2 <= ps2_key.pressed;
                    KEY_COIN1:  keys.coin1  <= ps2_key.pressed;
                    KEY_COIN2:  keys.coin2  <= ps2_key.pressed;
                    KEY_PAUSE:  keys.pause  <= ps2_key.pressed;

                    // Directions, shared by all players
                    KEY_UP:     keys.up     <= ps2_key.pressed;
                    KEY_DOWN:   keys.down   <= ps2_key.pressed;
                    KEY_LEFT:   keys.left   <= ps2_key.pressed;
                    KEY_RIGHT:  keys.right  <= ps2_key.pressed;

                    // Fire buttons
                    KEY_A:      keys.a      <= ps2_key.pressed;
                    KEY_B:      keys.b      <= ps2_key.pressed;
                    KEY_X:      keys.x      <= ps2_key.pressed;
                    KEY_Y:      keys.y      <= ps2_key.pressed;

                    // Anything else leaves the held state alone
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Held buttons only move on a toggle change
    a_keys_hold: assert property (
        @(posedge CLK_32M) disable iff (!rst_n)
        !key_event |=> $stable(keys)
    ) else $error("keys changed without a keyboard event");

endmodule

//--- source/arcade_input_pkg.sv
//////////////////////////////////////////////////
// Shared types for the arcade input front end
// Imported by every module of the controls path
//////////////////////////////////////////////////

package arcade_input_pkg;

    // Keyboard scan codes recognized by the decoder
    typedef enum logic [7:0] {
        KEY_START1 = 8'h16,
        KEY_START2 = 8'h1E,
        KEY_COIN1  = 8'h2E,
        KEY_COIN2  = 8'h36,
        KEY_PAUSE  = 8'h4D,
        KEY_UP     = 8'h75,
        KEY_DOWN   = 8'h72,
        KEY_LEFT   = 8'h6B,
        KEY_RIGHT  = 8'h74,
        KEY_A      = 8'h14,
        KEY_B      = 8'h11,
        KEY_X      = 8'h29,
        KEY_Y      = 8'h12
    } key_code_e;

    // One keyboard event, toggle flips per event
    typedef struct packed {
        logic       toggle;
        logic       pressed;
        logic       extended;
        logic [7:0] code;
    } ps2_key_t;

    // Held keyboard buttons
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic x;
        logic y;
        logic coin1;
        logic coin2;
        logic start1;
        logic start2;
        logic pause;
    } key_state_t;

    // Gamepad word and its bit positions, 12 to 15 unused
    typedef logic [15:0] pad_t;

    localparam int PAD_RIGHT  = 0;
    localparam int PAD_LEFT   = 1;
    localparam int PAD_DOWN   = 2;
    localparam int PAD_UP     = 3;
    localparam int PAD_A      = 4;
    localparam int PAD_B      = 5;
    localparam int PAD_X      = 6;
    localparam int PAD_Y      = 7;
    localparam int PAD_START1 = 8;
    localparam int PAD_COIN1  = 9;
    localparam int PAD_START2 = 10;
    localparam int PAD_PAUSE  = 11;

    // Per-player controls, all active high
    typedef struct packed {
        logic [3:0] joystick;   // up, down, left, right
        logic [3:0] buttons;    // a, b, x, y
        logic       start1;
        logic       coin1;
        logic       start2;
        logic       pause;
    } player_ctrl_t;

    // One write from the download channel
    typedef struct packed {
        logic        wr;
        logic [7:0]  index;
        logic [16:0] addr;
        logic [7:0]  data;
    } dip_write_t;

    localparam logic [7:0] DIP_INDEX = 8'd254;
    localparam int         DIP_BYTES = 8;

endpackage
